//--- bench/botPermuterTb.sv
`timescale 1ns/10ps

module botPermuterTb import permPkg::*; ();

    localparam int SetSize = NumPerms / NumVars;
    localparam int Test1Cycles = 16;
    localparam int Test2Cycles = NumPerms + 16;
    localparam int Test3Cycles = 7 * NumPerms + 32;
    localparam int Test4Cycles = 16;
    localparam int Test5Cycles = 3 * NumPerms * 8 + 32;   // slowDown high about half the time
    localparam int Test6Cycles = 32 * NumPerms + 64;
    localparam int TimeoutCycles = 2 * (3 + Test1Cycles + Test2Cycles + Test3Cycles
                                      + Test4Cycles + Test5Cycles + Test6Cycles + 8);

    logic clk;
    logic rst;
    logic writeDataIn;
    botT  botIn;
    maskT validPermutesIn;
    logic lastBotOfBatchIn;
    logic almostFull;
    logic slowDown;
    logic permutedBotValid;
    botT  permutedBot;
    logic batchDone;

    int   sigma [NumPerms][NumVars];   // Lexicographic permutations as sigma[k][q]
    botT  expBotQ [$];
    logic expValidQ [$];
    logic expDoneQ [$];
    botT  outBotQ [$];
    logic outValidQ [$];
    logic outDoneQ [$];
    int   errors;
    int   checks;
    int   testsRun;
    int   cycles;
    logic jitter;                      // Random slowDown on every cycle

    botPermuter #(
        .DepthLog2(5),
        .AlmostFullMargin(4)
    ) botPermuter_inst (
        .clk(clk),
        .rst(rst),
        .writeDataIn(writeDataIn),
        .botIn(botIn),
        .validPermutesIn(validPermutesIn),
        .lastBotOfBatchIn(lastBotOfBatchIn),
        .almostFull(almostFull),
        .slowDown(slowDown),
        .permutedBotValid(permutedBotValid),
        .permutedBot(permutedBot),
        .batchDone(batchDone)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, expected outputs never arrived", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // Registered outputs are stable on the falling edge
    always @(negedge clk) begin
        if (!rst && (permutedBotValid || batchDone)) begin
            outBotQ.push_back(permutedBotValid ? permutedBot : '0);
            outValidQ.push_back(permutedBotValid);
            outDoneQ.push_back(batchDone);
        end
    end

    task automatic buildPermList();
        int k;
        int d [NumVars];
        logic distinct;
        k = 0;
        // Counting in base 4 walks all sequences in lexicographic order
        for (int n = 0; n < 256; n++) begin
            for (int q = 0; q < NumVars; q++) begin
                d[q] = (n >> (2 * (NumVars - 1 - q))) & 3;
            end
            distinct = 1'b1;
            for (int a = 0; a < NumVars; a++) begin
                for (int b = a + 1; b < NumVars; b++) begin
                    if (d[a] == d[b]) distinct = 1'b0;
                end
            end
            if (distinct) begin
                for (int q = 0; q < NumVars; q++) sigma[k][q] = d[q];
                k++;
            end
        end
    endtask

    function automatic botT permuteBot(botT b, int k);
        botT r;
        logic [3:0] i;
        logic [3:0] jBits;
        for (int j = 0; j < 16; j++) begin
            jBits = 4'(j);
            i = '0;
            for (int q = 0; q < NumVars; q++) begin
                i[sigma[k][q]] = jBits[q];   // Bit sigma(q) of i is bit q of j
            end
            r[8 * j +: 8] = b[8 * i +: 8];
        end
        return r;
    endfunction

    task automatic expectBot(botT b, maskT m, logic last);
        int total;
        int issued;
        int k;
        total = $countones(m);
        issued = 0;
        if (total == 0 && last) begin
            expBotQ.push_back('0);
            expValidQ.push_back(1'b0);
            expDoneQ.push_back(1'b1);
        end
        for (int p = 0; p < SetSize; p++) begin
            for (int s = 0; s < NumVars; s++) begin
                k = SetSize * s + p;
                if (m[k]) begin
                    issued++;
                    expBotQ.push_back(permuteBot(b, k));
                    expValidQ.push_back(1'b1);
                    expDoneQ.push_back(last && issued == total);
                end
            end
        end
    endtask

    task automatic compare(string testName, logic [127:0] expected, logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(negedge clk);
        if (jitter) slowDown = $urandom_range(0, 1);
    endtask

    task automatic writeBot(botT b, maskT m, logic last);
        while (almostFull) nextCycle();
        writeDataIn = 1'b1;
        botIn = b;
        validPermutesIn = m;
        lastBotOfBatchIn = last;
        expectBot(b, m, last);
        nextCycle();
        writeDataIn = 1'b0;
    endtask

    task automatic checkOutputs(string testName);
        while (outValidQ.size() < expValidQ.size()) nextCycle();
        while (expValidQ.size() > 0) begin
            compare(testName, expValidQ[0], outValidQ[0]);
            compare(testName, expDoneQ[0], outDoneQ[0]);
            if (expValidQ[0]) compare(testName, expBotQ[0], outBotQ[0]);
            void'(expBotQ.pop_front());
            void'(expValidQ.pop_front());
            void'(expDoneQ.pop_front());
            void'(outBotQ.pop_front());
            void'(outValidQ.pop_front());
            void'(outDoneQ.pop_front());
        end
    endtask

    task automatic reportTest(string testName, int errBefore);
        testsRun++;
        $display("Test %s finished with %0d errors", testName, errors - errBefore);
    endtask

    function automatic botT randomBot();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic identityTest();
        int errBefore;
        errBefore = errors;
        writeBot(randomBot(), 24'h00_0001, 1'b1);   // k = 0 leaves the bot as it is
        checkOutputs("identity");
        reportTest("identity", errBefore);
    endtask

    task automatic fullMaskTest();
        int errBefore;
        errBefore = errors;
        writeBot(randomBot(), '1, 1'b1);
        checkOutputs("fullMask");
        reportTest("fullMask", errBefore);
    endtask

    task automatic twoBatchTest();
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < 3; i++) writeBot(randomBot(), maskT'($urandom()), i == 2);
        for (int i = 0; i < 4; i++) writeBot(randomBot(), maskT'($urandom()), i == 3);
        checkOutputs("twoBatch");
        reportTest("twoBatch", errBefore);
    endtask

    task automatic emptyLastTest();
        int errBefore;
        errBefore = errors;
        writeBot(randomBot(), '0, 1'b1);
        checkOutputs("emptyLast");
        reportTest("emptyLast", errBefore);
    endtask

    task automatic slowDownTest();
        int errBefore;
        errBefore = errors;
        jitter = 1'b1;
        for (int i = 0; i < 3; i++) writeBot(randomBot(), '1, i == 2);
        checkOutputs("slowDown");
        jitter = 1'b0;
        slowDown = 1'b0;
        reportTest("slowDown", errBefore);
    endtask

    task automatic fillTest();
        int errBefore;
        int writes;
        maskT m;
        botT b;
        errBefore = errors;
        writes = 0;
        slowDown = 1'b1;
        // One bot moves into the decode stage, so 30 writes leave 3 entries free
        while (!almostFull && writes < 32) begin
            b = randomBot();
            m = maskT'($urandom());
            writeDataIn = 1'b1;
            botIn = b;
            validPermutesIn = m;
            lastBotOfBatchIn = 1'b0;
            expectBot(b, m, 1'b0);
            nextCycle();
            writes++;
        end
        writeDataIn = 1'b0;
        compare("fill", 30, writes);
        compare("fill", 1, almostFull);
        compare("fill", 0, outValidQ.size());
        slowDown = 1'b0;
        writeBot(randomBot(), '1, 1'b1);   // Waits for almostFull to fall
        checkOutputs("fill");
        reportTest("fill", errBefore);
    endtask

    initial begin
        void'($urandom(32'h93ee_a2ce));
        rst = 1'b1;
        writeDataIn = 1'b0;
        botIn = '0;
        validPermutesIn = '0;
        lastBotOfBatchIn = 1'b0;
        slowDown = 1'b0;
        jitter = 1'b0;
        errors = 0;
        checks = 0;
        testsRun = 0;
        buildPermList();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        identityTest();
        fullMaskTest();
        twoBatchTest();
        emptyLastTest();
        slowDownTest();
        fillTest();

        repeat (4) nextCycle();
        compare("idle", 0, outValidQ.size());   // Nothing beyond the expected outputs
        if (botPermuter_inst.protocolChecks.failCount != 0) begin
            errors++;
            $display("Protocol assertions failed %0d times",
                     botPermuter_inst.protocolChecks.failCount);
        end

        $display("Tests run %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/botPermuter_assertions.sv
`timescale 1ns/10ps

module botPermuter_assertions (
    input logic clk,
    input logic rst,
    input logic writeDataIn,
    input logic lastBotOfBatchIn,
    input logic full,
    input logic almostFull,
    input logic slowDown,
    input logic selValid,
    input logic permutedBotValid,
    input logic batchDone
);

    int openBatches;   // Batches written but not yet closed by batchDone
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            openBatches <= 0;
        end else begin
            openBatches <= openBatches + int'(writeDataIn && !full && lastBotOfBatchIn)
                         - int'(batchDone);
        end
    end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        writeDataIn |-> !full)
        else begin failCount++; $error("write into a full store"); end

    lowAfterReset: assert property (@(posedge clk)
        $past(rst) |-> !almostFull && !permutedBotValid && !batchDone)
        else begin failCount++; $error("outputs not cleared by reset"); end

    noIssueAfterSlowDown: assert property (@(posedge clk) disable iff (rst)
        selValid |-> !$past(slowDown))
        else begin failCount++; $error("selection issued while slowDown was high"); end

    oneDonePerBatch: assert property (@(posedge clk) disable iff (rst)
        batchDone |-> openBatches > 0)
        else begin failCount++; $error("batchDone without an open batch"); end

endmodule

bind botPermuter botPermuter_assertions protocolChecks (
    .clk(clk),
    .rst(rst),
    .writeDataIn(writeDataIn),
    .lastBotOfBatchIn(lastBotOfBatchIn),
    .full(botFifo_inst.full),
    .almostFull(almostFull),
    .slowDown(slowDown),
    .selValid(sel.selValid),
    .permutedBotValid(permutedBotValid),
    .batchDone(batchDone)
);

//--- design/botFifo.sv
`timescale 1ns/10ps

module botFifo import permPkg::*; #(
    parameter int DepthLog2 = 5,
    parameter int AlmostFullMargin = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic write,
    input  botT  botIn,
    input  maskT maskIn,
    input  logic lastIn,
    output logic almostFull,
    headIf.store head
);

    localparam int Depth = 2 ** DepthLog2;

    typedef logic [DepthLog2:0] ptrT;   // Extra wrap bit on top

    localparam ptrT HighLevel = ptrT'(Depth - AlmostFullMargin);

    botT  botMem [Depth];
    maskT maskMem [Depth];
    logic lastMem [Depth];

    ptrT  wrPtr;
    ptrT  rdPtr;
    ptrT  wrPtrNext;
    ptrT  rdPtrNext;
    ptrT  levelNext;
    logic full;
    logic wrEn;
    logic popEn;

    // Same slot, different lap
    assign full = (wrPtr[DepthLog2] != rdPtr[DepthLog2])
               && (wrPtr[DepthLog2-1:0] == rdPtr[DepthLog2-1:0]);

    assign wrEn = write && !full;
    assign popEn = head.pop && head.headValid;

    assign wrPtrNext = wrPtr + ptrT'(wrEn);
    assign rdPtrNext = rdPtr + ptrT'(popEn);
    assign levelNext = wrPtrNext - rdPtrNext;   // Includes the entry held at the head

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            head.headValid <= 1'b0;
            almostFull <= 1'b0;
        end else begin
            wrPtr <= wrPtrNext;
            rdPtr <= rdPtrNext;
            // A write in this cycle shows at the head one edge later
            head.headValid <= wrPtr != rdPtrNext;
            almostFull <= levelNext > HighLevel;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            botMem[wrPtr[DepthLog2-1:0]] <= botIn;
            maskMem[wrPtr[DepthLog2-1:0]] <= maskIn;
            lastMem[wrPtr[DepthLog2-1:0]] <= lastIn;
        end
    end

    // Registered read of the next head, address moves ahead on a pop
    always_ff @(posedge clk) begin
        head.headBot <= botMem[rdPtrNext[DepthLog2-1:0]];
        head.headMask <= maskMem[rdPtrNext[DepthLog2-1:0]];
        head.headLast <= lastMem[rdPtrNext[DepthLog2-1:0]];
    end

endmodule

//--- design/botPermuter.sv
`timescale 1ns/10ps

module botPermuter import permPkg::*; #(
    parameter int DepthLog2 = 5,
    parameter int AlmostFullMargin = 4
) (
    input  logic clk,
    input  logic rst,

    // Writer side
    input  logic writeDataIn,
    input  botT  botIn,
    input  maskT validPermutesIn,
    input  logic lastBotOfBatchIn,
    output logic almostFull,

    // Reader side
    input  logic slowDown,
    output logic permutedBotValid,
    output botT  permutedBot,
    output logic batchDone
);

    headIf head ();
    selIf  sel ();

    botFifo #(
        .DepthLog2(DepthLog2),
        .AlmostFullMargin(AlmostFullMargin)
    ) botFifo_inst (
        .clk(clk),
        .rst(rst),
        .write(writeDataIn),
        .botIn(botIn),
        .maskIn(validPermutesIn),
        .lastIn(lastBotOfBatchIn),
        .almostFull(almostFull),
        .head(head.store)
    );

    permSelect permSelect_inst (
        .clk(clk),
        .rst(rst),
        .slowDown(slowDown),
        .head(head.select),
        .sel(sel.issue)
    );

    permNetwork permNetwork_inst (
        .clk(clk),
        .rst(rst),
        .sel(sel.execute),
        .permutedBotValid(permutedBotValid),
        .permutedBot(permutedBot),
        .batchDone(batchDone)
    );

endmodule

//--- design/permIfs.sv
`timescale 1ns/10ps

// Head of the bot store, show-ahead
interface headIf import permPkg::*; ();

    logic headValid;
    botT  headBot;
    maskT headMask;
    logic headLast;
    logic pop;

    modport store (
        output headValid, headBot, headMask, headLast,
        input  pop
    );

    modport select (
        input  headValid, headBot, headMask, headLast,
        output pop
    );

endinterface

// One selected permutation of a held bot, no stall
interface selIf import permPkg::*; ();

    logic    selValid;
    botT     selBot;
    setIdxT  selSet;
    permIdxT selPerm;
    logic    selLast;

    modport issue (
        output selValid, selBot, selSet, selPerm, selLast
    );

    modport execute (
        input selValid, selBot, selSet, selPerm, selLast
    );

endinterface

//--- design/permNetwork.sv
`timescale 1ns/10ps

module permNetwork import permPkg::*; (
    input  logic clk,
    input  logic rst,
    selIf.execute sel,
    output logic permutedBotValid,
    output botT  permutedBot,
    output logic batchDone
);

    localparam int NumEntries = 2 ** NumVars;

    logic [4:0] tableIdx;
    logic [7:0] code;
    entryT      entries [NumEntries];
    botT        routed;

    assign tableIdx = 5'(sel.selSet) * 5'(PermsPerSet) + 5'(sel.selPerm);
    assign code = permTable[tableIdx];

    always_comb begin
        for (int e = 0; e < NumEntries; e++) begin
            entries[e] = sel.selBot[8 * e +: 8];
        end
    end

    // Output entry j reads input entry i with i[sigma(q)] = j[q]
    always_comb begin
        logic [NumVars-1:0] src;
        routed = '0;
        for (int j = 0; j < NumEntries; j++) begin
            src = '0;
            for (int q = 0; q < NumVars; q++) begin
                src[code[2 * q +: 2]] = j[q];
            end
            routed[8 * j +: 8] = entries[src];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            permutedBotValid <= 1'b0;
            batchDone <= 1'b0;
        end else begin
            permutedBotValid <= sel.selValid;
            batchDone <= sel.selLast;   // Can come alone for an empty last bot
        end
    end

    always_ff @(posedge clk) begin
        if (sel.selValid) begin
            permutedBot <= routed;
        end
    end

endmodule

//--- design/permPkg.sv
package permPkg;

    localparam int NumVars = 4;
    localparam int NumPerms = 24;
    localparam int PermsPerSet = NumPerms / NumVars;   // 6 orderings per set

    typedef logic [7:0] entryT;
    typedef logic [127:0] botT;                        // 16 entries, entry j at bits 8j+7..8j
    typedef logic [NumPerms-1:0] maskT;                // Bit k is permutation k = 6*set + perm
    typedef logic [1:0] setIdxT;
    typedef logic [2:0] permIdxT;

    typedef enum logic {
        sIdle,
        sWalk
    } selStateT;

    // Lexicographic permutations of {0,1,2,3}
    // Field q (bits 2q+1..2q) holds sigma(q)
    localparam logic [7:0] permTable [0:NumPerms-1] = '{
        8'b11_10_01_00,   // 0123
        8'b10_11_01_00,   // 0132
        8'b11_01_10_00,   // 0213
        8'b01_11_10_00,   // 0231
        8'b10_01_11_00,   // 0312
        8'b01_10_11_00,   // 0321
        8'b11_10_00_01,   // 1023
        8'b10_11_00_01,   // 1032
        8'b11_00_10_01,   // 1203
        8'b00_11_10_01,   // 1230
        8'b10_00_11_01,   // 1302
        8'b00_10_11_01,   // 1320
        8'b11_01_00_10,   // 2013
        8'b01_11_00_10,   // 2031
        8'b11_00_01_10,   // 2103
        8'b00_11_01_10,   // 2130
        8'b01_00_11_10,   // 2301
        8'b00_01_11_10,   // 2310
        8'b10_01_00_11,   // 3012
        8'b01_10_00_11,   // 3021
        8'b10_00_01_11,   // 3102
        8'b00_10_01_11,   // 3120
        8'b01_00_10_11,   // 3201
        8'b00_01_10_11    // 3210
    };

endpackage

//--- design/permSelect.sv
`timescale 1ns/10ps

module permSelect import permPkg::*; (
    input logic clk,
    input logic rst,
    input logic slowDown,
    headIf.select head,
    selIf.issue sel
);

    selStateT state;
    botT      heldBot;
    maskT     pending;    // Held mask in permutation-major order
    logic     heldLast;

    maskT       remaining;
    logic [4:0] lowIdx;
    logic       issue;
    logic       walkDone;
    logic       loadHead;

    // Bit 4*perm + set of the result is bit 6*set + perm of the mask
    function automatic maskT permMajor(input maskT m);
        maskT r;
        r = '0;
        for (int p = 0; p < PermsPerSet; p++) begin
            for (int s = 0; s < NumVars; s++) begin
                r[p * NumVars + s] = m[s * PermsPerSet + p];
            end
        end
        return r;
    endfunction

    function automatic logic [4:0] firstSet(input maskT m);
        logic [4:0] idx;
        idx = '0;
        for (int b = NumPerms - 1; b >= 0; b--) begin
            if (m[b]) begin
                idx = 5'(b);
            end
        end
        return idx;
    endfunction

    assign lowIdx = firstSet(pending);
    assign remaining = pending & (pending - 1'b1);   // Drop the lowest pending bit

    assign issue = (state == sWalk) && !slowDown;
    assign walkDone = remaining == '0;               // Also true for an empty mask

    // Back to back bots: the next head loads with the last issue
    assign loadHead = head.headValid && ((state == sIdle) || (issue && walkDone));
    assign head.pop = loadHead;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            sel.selValid <= 1'b0;
            sel.selLast <= 1'b0;
        end else begin
            sel.selValid <= issue && (pending != '0);
            sel.selLast <= issue && walkDone && heldLast;
            if (loadHead) begin
                state <= sWalk;
            end else if (issue && walkDone) begin
                state <= sIdle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadHead) begin
            heldBot <= head.headBot;
            pending <= permMajor(head.headMask);
            heldLast <= head.headLast;
        end else if (issue) begin
            pending <= remaining;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            sel.selBot <= heldBot;
            sel.selSet <= setIdxT'(lowIdx[1:0]);
            sel.selPerm <= permIdxT'(lowIdx[4:2]);
        end
    end

endmodule

//--- vlog.f
design/permPkg.sv
design/permIfs.sv
design/botFifo.sv
design/permSelect.sv
design/permNetwork.sv
design/botPermuter.sv
bench/botPermuter_assertions.sv
bench/botPermuterTb.sv
